// File: verilog/cpu_pkg.sv
package cpu_pkg;

        localparam int WORD_SIZE    = 16;       // data and address width
        localparam int NUM_REGS     = 4;
        localparam int REG_ADDR_W   = 2;
        localparam int OPC_WIDTH    = 4;
        localparam int FUNC_WIDTH   = 6;

        // instruction field positions
        localparam int OPC_MSB      = 15;
        localparam int RS_MSB       = 11;
        localparam int RT_MSB       = 9;
        localparam int RD_MSB       = 7;
        localparam int IMM_WIDTH    = 8;
        localparam int TARGET_WIDTH = 12;       // jump target field

        typedef enum logic [OPC_WIDTH-1:0] {
                OP_BNE   = 4'd0,
                OP_BEQ   = 4'd1,
                OP_ADI   = 4'd4,
                OP_LHI   = 4'd6,
                OP_LWD   = 4'd7,
                OP_SWD   = 4'd8,
                OP_JMP   = 4'd9,
                OP_RTYPE = 4'd15
        } opcode_t;

        typedef enum logic [FUNC_WIDTH-1:0] {
                FN_ADD = 6'd0,
                FN_SUB = 6'd1,
                FN_AND = 6'd2,
                FN_ORR = 6'd3,
                FN_NOT = 6'd4,
                FN_TCP = 6'd5,
                FN_SHL = 6'd6,
                FN_SHR = 6'd7,
                FN_WWD = 6'd28,
                FN_HLT = 6'd29
        } func_t;

        typedef enum logic [2:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
        } alu_op_t;

        typedef enum logic [2:0] {
                S_IF, S_ID, S_EX, S_MEM, S_WB, S_HALT
        } state_t;

        // next pc source
        typedef enum logic [1:0] {
                PC_SEQ, PC_BRANCH, PC_JUMP
        } pc_src_t;

endpackage

// File: verilog/ctrl_if.sv
interface ctrl_if import cpu_pkg::*; ();

        logic    pc_write, ir_write, mdr_write, reg_write, out_write, inst_done;
        logic    i_read_en, d_read_en, d_write_en;
        logic    halted;
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    reg_dst_rd;    // rd instead of rt as destination
        logic    mem_to_reg;
        logic    lhi_sel;
        pc_src_t pc_src;

        // decoded fields and compare result, back from the datapath
        opcode_t opcode;
        func_t   func;
        logic    cmp_equal;

        modport ctl (
                output pc_write, ir_write, mdr_write, reg_write, out_write, inst_done,
                output i_read_en, d_read_en, d_write_en, halted,
                output alu_op, alu_src_imm, reg_dst_rd, mem_to_reg, lhi_sel, pc_src,
                input  opcode, func, cmp_equal
        );

        modport dp (
                input  pc_write, ir_write, mdr_write, reg_write, out_write, inst_done,
                input  alu_op, alu_src_imm, reg_dst_rd, mem_to_reg, lhi_sel, pc_src,
                output opcode, func, cmp_equal
        );

endinterface

// File: verilog/alu.sv
module alu import cpu_pkg::*; (
        input  alu_op_t              i_op,
        input  logic [WORD_SIZE-1:0] i_a,
        input  logic [WORD_SIZE-1:0] i_b,
        output logic [WORD_SIZE-1:0] o_result
);

        always_comb begin
                case (i_op)
                        ALU_ADD: o_result = i_a + i_b;
                        ALU_SUB: o_result = i_a - i_b;
                        ALU_AND: o_result = i_a & i_b;
                        ALU_OR:  o_result = i_a | i_b;
                        ALU_NOT: o_result = ~i_a;
                        ALU_TCP: o_result = ~i_a + 1'b1;   // two's complement
                        ALU_SHL: o_result = {i_a[WORD_SIZE-2:0], 1'b0};
                        // arithmetic shift keeps the sign bit
                        ALU_SHR: o_result = {i_a[WORD_SIZE-1], i_a[WORD_SIZE-1:1]};
                        default: o_result = '0;
                endcase
        end

endmodule

// File: verilog/register_file.sv
module register_file import cpu_pkg::*; (
        input  logic                  i_clk,
        input  logic                  i_rst,
        input  logic [REG_ADDR_W-1:0] i_rs_addr,
        input  logic [REG_ADDR_W-1:0] i_rt_addr,
        output logic [WORD_SIZE-1:0]  o_rs_data,
        output logic [WORD_SIZE-1:0]  o_rt_data,
        input  logic                  i_we,
        input  logic [REG_ADDR_W-1:0] i_wr_addr,
        input  logic [WORD_SIZE-1:0]  i_wr_data
);

        logic [WORD_SIZE-1:0] regs [NUM_REGS];

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        for (int i = 0; i < NUM_REGS; i++)
                                regs[i] <= '0;
                end else if (i_we) begin
                        regs[i_wr_addr] <= i_wr_data;   // lands at the next edge
                end
        end

        // combinational reads, no write bypass
        assign o_rs_data = regs[i_rs_addr];
        assign o_rt_data = regs[i_rt_addr];

endmodule

// File: verilog/control_unit.sv
module control_unit import cpu_pkg::*; (
        input  logic i_clk,
        input  logic i_rst,
        ctrl_if.ctl  u_ctrl
);

        state_t state, state_next;
        logic   started;
        logic   is_rtype, is_alu_r, is_wwd, is_hlt;
        logic   is_jump, is_load, is_store, writes_reg;
        logic   branch_taken;

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        state   <= S_IF;
                        started <= 1'b0;
                end else begin
                        state   <= state_next;
                        started <= 1'b1;   // one idle cycle out of reset
                end
        end

        assign is_rtype   = u_ctrl.opcode == OP_RTYPE;
        assign is_alu_r   = is_rtype && (u_ctrl.func <= FN_SHR);
        assign is_wwd     = is_rtype && (u_ctrl.func == FN_WWD);
        assign is_hlt     = is_rtype && (u_ctrl.func == FN_HLT);
        assign is_jump    = u_ctrl.opcode == OP_JMP;
        assign is_load    = u_ctrl.opcode == OP_LWD;
        assign is_store   = u_ctrl.opcode == OP_SWD;
        assign writes_reg = is_alu_r || is_load || (u_ctrl.opcode == OP_ADI)
                            || (u_ctrl.opcode == OP_LHI);

        // only place the branch outcome is decided
        assign branch_taken = ((u_ctrl.opcode == OP_BEQ) && u_ctrl.cmp_equal)
                              || ((u_ctrl.opcode == OP_BNE) && !u_ctrl.cmp_equal);

        always_comb begin
                case (state)
                        S_IF:    state_next = started ? S_ID : S_IF;
                        S_ID:    state_next = is_hlt ? S_HALT : S_EX;
                        S_EX: begin
                                if (is_load || is_store)
                                        state_next = S_MEM;
                                else if (writes_reg)
                                        state_next = S_WB;
                                else
                                        state_next = S_IF;   // branch, jump, wwd
                        end
                        S_MEM:   state_next = is_load ? S_WB : S_IF;
                        S_WB:    state_next = S_IF;
                        default: state_next = S_HALT;
                endcase
        end

        always_comb begin
                case (u_ctrl.func)
                        FN_SUB:  u_ctrl.alu_op = ALU_SUB;
                        FN_AND:  u_ctrl.alu_op = ALU_AND;
                        FN_ORR:  u_ctrl.alu_op = ALU_OR;
                        FN_NOT:  u_ctrl.alu_op = ALU_NOT;
                        FN_TCP:  u_ctrl.alu_op = ALU_TCP;
                        FN_SHL:  u_ctrl.alu_op = ALU_SHL;
                        FN_SHR:  u_ctrl.alu_op = ALU_SHR;
                        default: u_ctrl.alu_op = ALU_ADD;
                endcase
                if (!is_rtype)
                        u_ctrl.alu_op = ALU_ADD;   // adi and address calc
        end

        assign u_ctrl.alu_src_imm = is_load || is_store || (u_ctrl.opcode == OP_ADI);
        assign u_ctrl.reg_dst_rd  = is_rtype;
        assign u_ctrl.mem_to_reg  = is_load;
        assign u_ctrl.lhi_sel     = u_ctrl.opcode == OP_LHI;

        // pc+1 in decode and redirect in execute
        assign u_ctrl.pc_write  = (state == S_ID)
                                  || ((state == S_EX) && (is_jump || branch_taken));
        assign u_ctrl.pc_src    = (state == S_ID) ? PC_SEQ : (is_jump ? PC_JUMP : PC_BRANCH);

        assign u_ctrl.i_read_en  = (state == S_IF) && started;
        assign u_ctrl.ir_write   = state == S_ID;
        assign u_ctrl.out_write  = (state == S_EX) && is_wwd;
        assign u_ctrl.d_read_en  = (state == S_MEM) && is_load;
        assign u_ctrl.d_write_en = (state == S_MEM) && is_store;
        assign u_ctrl.mdr_write  = (state == S_WB) && is_load;
        assign u_ctrl.reg_write  = state == S_WB;
        assign u_ctrl.inst_done  = (state != S_IF) && (state_next == S_IF);
        assign u_ctrl.halted     = state == S_HALT;

endmodule

// File: verilog/datapath.sv
module datapath import cpu_pkg::*; (
        input  logic                 i_clk,
        input  logic                 i_rst,
        ctrl_if.dp                   u_ctrl,
        output logic [WORD_SIZE-1:0] o_i_address,
        input  logic [WORD_SIZE-1:0] i_i_data,
        output logic [WORD_SIZE-1:0] o_d_address,
        output logic [WORD_SIZE-1:0] o_d_wdata,
        input  logic [WORD_SIZE-1:0] i_d_rdata,
        output logic [WORD_SIZE-1:0] o_output_port,
        output logic [WORD_SIZE-1:0] o_num_inst
);

        logic [WORD_SIZE-1:0]  pc, pc_next, ir, inst;
        logic [WORD_SIZE-1:0]  mdr, load_data, alu_out, alu_result;
        logic [WORD_SIZE-1:0]  imm_ext, alu_b, rs_data, rt_data, wr_data;
        logic [REG_ADDR_W-1:0] wr_addr;

        // the word arriving in decode is seen by control right away
        assign inst          = u_ctrl.ir_write ? i_i_data : ir;
        assign u_ctrl.opcode = opcode_t'(inst[OPC_MSB -: OPC_WIDTH]);
        assign u_ctrl.func   = func_t'(inst[FUNC_WIDTH-1:0]);

        assign imm_ext = {{(WORD_SIZE-IMM_WIDTH){ir[IMM_WIDTH-1]}}, ir[IMM_WIDTH-1:0]};

        register_file u_regs (
                .i_clk     (i_clk),
                .i_rst     (i_rst),
                .i_rs_addr (ir[RS_MSB -: REG_ADDR_W]),
                .i_rt_addr (ir[RT_MSB -: REG_ADDR_W]),
                .o_rs_data (rs_data),
                .o_rt_data (rt_data),
                .i_we      (u_ctrl.reg_write),
                .i_wr_addr (wr_addr),
                .i_wr_data (wr_data)
        );

        assign u_ctrl.cmp_equal = rs_data == rt_data;
        assign alu_b = u_ctrl.alu_src_imm ? imm_ext : rt_data;

        alu u_alu (
                .i_op     (u_ctrl.alu_op),
                .i_a      (rs_data),
                .i_b      (alu_b),
                .o_result (alu_result)
        );

        assign load_data = u_ctrl.mdr_write ? i_d_rdata : mdr;   // write-through on capture
        assign wr_addr   = u_ctrl.reg_dst_rd ? ir[RD_MSB -: REG_ADDR_W] : ir[RT_MSB -: REG_ADDR_W];

        always_comb begin
                if (u_ctrl.mem_to_reg)
                        wr_data = load_data;
                else if (u_ctrl.lhi_sel)
                        wr_data = {ir[IMM_WIDTH-1:0], {(WORD_SIZE-IMM_WIDTH){1'b0}}};
                else
                        wr_data = alu_out;
        end

        // pc already holds pc+1 when a branch or jump resolves
        always_comb begin
                case (u_ctrl.pc_src)
                        PC_BRANCH: pc_next = pc + imm_ext;
                        PC_JUMP:   pc_next = {pc[WORD_SIZE-1 -: WORD_SIZE-TARGET_WIDTH],
                                              ir[TARGET_WIDTH-1:0]};
                        default:   pc_next = pc + 1'b1;
                endcase
        end

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        pc            <= '0;
                        o_output_port <= '0;
                        o_num_inst    <= '0;
                end else begin
                        if (u_ctrl.pc_write)
                                pc <= pc_next;
                        if (u_ctrl.out_write)
                                o_output_port <= rs_data;   // wwd outputs rs
                        if (u_ctrl.inst_done)
                                o_num_inst <= o_num_inst + 1'b1;
                end
        end

        always_ff @(posedge i_clk) begin
                if (u_ctrl.ir_write)
                        ir <= i_i_data;
                if (u_ctrl.mdr_write)
                        mdr <= i_d_rdata;
                alu_out <= alu_result;   // stable from execute onward
        end

        assign o_i_address = pc;
        assign o_d_address = alu_out;
        assign o_d_wdata   = rt_data;

endmodule

// File: verilog/cpu.sv
module cpu import cpu_pkg::*; (
        input  logic                 i_clk,
        input  logic                 i_rst,

        output logic                 o_i_read,
        output logic [WORD_SIZE-1:0] o_i_address,
        input  logic [WORD_SIZE-1:0] i_i_data,

        output logic                 o_d_read,
        output logic                 o_d_write,
        output logic [WORD_SIZE-1:0] o_d_address,
        output logic [WORD_SIZE-1:0] o_d_wdata,
        input  logic [WORD_SIZE-1:0] i_d_rdata,

        output logic [WORD_SIZE-1:0] o_output_port,
        output logic [WORD_SIZE-1:0] o_num_inst,
        output logic                 o_is_halted
);

        ctrl_if u_ctrl_if ();

        control_unit u_control (
                .i_clk  (i_clk),
                .i_rst  (i_rst),
                .u_ctrl (u_ctrl_if.ctl)
        );

        datapath u_datapath (
                .i_clk         (i_clk),
                .i_rst         (i_rst),
                .u_ctrl        (u_ctrl_if.dp),
                .o_i_address   (o_i_address),
                .i_i_data      (i_i_data),
                .o_d_address   (o_d_address),
                .o_d_wdata     (o_d_wdata),
                .i_d_rdata     (i_d_rdata),
                .o_output_port (o_output_port),
                .o_num_inst    (o_num_inst)
        );

        // memory strobes come straight from control
        assign o_i_read    = u_ctrl_if.i_read_en;
        assign o_d_read    = u_ctrl_if.d_read_en;
        assign o_d_write   = u_ctrl_if.d_write_en;
        assign o_is_halted = u_ctrl_if.halted;

endmodule

// File: bench/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

        localparam int MEM_DEPTH  = 256;
        localparam int HALT_LIMIT = 4000;
        localparam logic [15:0] MARKER = 16'h7e11;   // skipped-path value

        logic        i_clk, i_rst;
        logic        o_i_read, o_d_read, o_d_write, o_is_halted;
        logic [15:0] o_i_address, i_i_data, o_d_address, o_d_wdata, i_d_rdata;
        logic [15:0] o_output_port, o_num_inst;

        logic [15:0] imem [MEM_DEPTH];
        logic [15:0] dmem [MEM_DEPTH];
        logic [15:0] lfsr, asm_pc, ls_start, br_start;
        logic [15:0] i_addr, d_addr, cur_inst, cur_addr, prev_num;
        logic        i_req, d_req, first_fetch;
        logic [15:0] exp_out[$], exp_st_addr[$], exp_st_data[$];
        int          model_count, value_errors, other_errors;

        cpu u_cpu (.*);

        initial begin
                i_clk = 1'b0;
                forever #20 i_clk = ~i_clk;
        end

        // galois lfsr stepped once per bit taken
        function automatic logic [7:0] rand_bits(input int n);
                logic [7:0] v;
                v = '0;
                for (int k = 0; k < n; k++) begin
                        v = {v[6:0], lfsr[0]};
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
                end
                return v;
        endfunction

        function automatic logic [15:0] r_type(input logic [1:0] rs, rt, rd, input logic [5:0] fn);
                return {OP_RTYPE, rs, rt, rd, fn};
        endfunction

        function automatic logic [15:0] i_type(input logic [3:0] op, input logic [1:0] rs, rt,
                                               input logic [7:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [15:0] wwd(input logic [1:0] rs);
                return r_type(rs, 2'd0, 2'd0, FN_WWD);
        endfunction

        task automatic emit(input logic [15:0] word);
                imem[asm_pc[7:0]] = word;
                asm_pc = asm_pc + 16'd1;
        endtask

        task automatic build_program();
                logic [7:0]  v, off;
                logic [1:0]  rd;
                logic [3:0]  op;
                logic [15:0] t;
                logic        equal, taken;
                for (int a = 0; a < MEM_DEPTH; a++)
                        imem[a] = r_type(2'd0, 2'd0, 2'd0, FN_HLT);   // runaway fetches halt
                asm_pc = '0;
                for (int f = 0; f < 8; f++) begin
                        v = rand_bits(2);
                        rd = v[1:0];
                        emit(i_type(OP_LHI, 2'd0, 2'd1, rand_bits(8)));
                        emit(wwd(2'd1));
                        emit(i_type(OP_ADI, 2'd1, 2'd1, rand_bits(8)));
                        emit(wwd(2'd1));
                        emit(i_type(OP_LHI, 2'd0, 2'd2, rand_bits(8)));
                        emit(i_type(OP_ADI, 2'd2, 2'd2, rand_bits(8)));
                        emit(r_type(2'd1, 2'd2, rd, f[5:0]));
                        emit(wwd(rd));
                end
                ls_start = asm_pc;
                for (int s = 0; s < 2; s++) begin
                        v = rand_bits(6);
                        emit(i_type(OP_LHI, 2'd0, 2'd1, 8'h00));
                        emit(i_type(OP_ADI, 2'd1, 2'd1, {2'b00, v[5:0]}));   // base 0..63
                        emit(i_type(OP_LHI, 2'd0, 2'd2, rand_bits(8)));
                        emit(i_type(OP_ADI, 2'd2, 2'd2, rand_bits(8)));
                        v = rand_bits(5);
                        off = {3'b000, v[4:0]};
                        emit(i_type(OP_SWD, 2'd1, 2'd2, off));
                        emit(i_type(OP_LHI, 2'd0, 2'd3, 8'h00));   // clear load target
                        emit(i_type(OP_LWD, 2'd1, 2'd3, off));
                        emit(wwd(2'd3));
                end
                br_start = asm_pc;
                emit(i_type(OP_LHI, 2'd0, 2'd3, MARKER[15:8]));
                emit(i_type(OP_ADI, 2'd3, 2'd3, MARKER[7:0]));
                // beq not taken, beq taken, bne taken, bne not taken
                for (int c = 0; c < 4; c++) begin
                        equal = c[0];
                        op = c[1] ? OP_BNE : OP_BEQ;
                        taken = c[1] ? !equal : equal;
                        v = rand_bits(8);
                        emit(i_type(OP_LHI, 2'd0, 2'd1, v));
                        emit(i_type(OP_LHI, 2'd0, 2'd2, v));
                        if (!equal)
                                emit(i_type(OP_ADI, 2'd2, 2'd2, 8'h01));
                        emit(i_type(op, 2'd1, 2'd2, 8'd2));
                        emit(wwd(taken ? 2'd3 : 2'd1));   // fall-through
                        t = asm_pc + 16'd2;
                        emit({OP_JMP, t[11:0]});
                        emit(wwd(taken ? 2'd1 : 2'd3));   // branch target
                end
                t = asm_pc + 16'd2;
                emit({OP_JMP, t[11:0]});
                emit(wwd(2'd3));
                emit(wwd(2'd2));
                emit(r_type(2'd0, 2'd0, 2'd0, FN_HLT));
        endtask

        // instruction set model run once before the dut starts
        task automatic run_model();
                logic [15:0] regs [4];
                logic [15:0] mem [MEM_DEPTH];
                logic [15:0] pc, inst, a, b, imm, addr;
                int          steps;
                for (int k = 0; k < 4; k++)
                        regs[k] = '0;
                for (int k = 0; k < MEM_DEPTH; k++)
                        mem[k] = dmem[k];
                pc = '0;
                model_count = 0;
                for (steps = 0; steps < 1000; steps++) begin
                        inst = imem[pc[7:0]];
                        a = regs[inst[11:10]];
                        b = regs[inst[9:8]];
                        imm = {{8{inst[7]}}, inst[7:0]};
                        addr = a + imm;
                        pc = pc + 16'd1;
                        if (inst[15:12] == OP_RTYPE && inst[5:0] == FN_HLT)
                                break;
                        model_count++;
                        case (inst[15:12])
                                OP_RTYPE: case (inst[5:0])
                                        FN_ADD:  regs[inst[7:6]] = a + b;
                                        FN_SUB:  regs[inst[7:6]] = a - b;
                                        FN_AND:  regs[inst[7:6]] = a & b;
                                        FN_ORR:  regs[inst[7:6]] = a | b;
                                        FN_NOT:  regs[inst[7:6]] = ~a;
                                        FN_TCP:  regs[inst[7:6]] = 16'd0 - a;
                                        FN_SHL:  regs[inst[7:6]] = a << 1;
                                        FN_SHR:  regs[inst[7:6]] = $signed(a) >>> 1;
                                        FN_WWD:  exp_out.push_back(a);
                                        default: ;
                                endcase
                                OP_ADI:  regs[inst[9:8]] = addr;
                                OP_LHI:  regs[inst[9:8]] = {inst[7:0], 8'h00};
                                OP_LWD:  regs[inst[9:8]] = mem[addr[7:0]];
                                OP_SWD: begin
                                        mem[addr[7:0]] = b;
                                        exp_st_addr.push_back(addr);
                                        exp_st_data.push_back(b);
                                end
                                OP_BEQ:  if (a == b) pc = pc + imm;
                                OP_BNE:  if (a != b) pc = pc + imm;
                                OP_JMP:  pc = {pc[15:12], inst[11:0]};
                                default: ;
                        endcase
                end
        endtask

        task automatic check_value(input string name, input logic [15:0] expected, actual);
                assert (actual === expected)
                else begin
                        value_errors++;
                        $display("Error %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        task automatic check_idle(input string name);
                assert (!o_i_read && !o_d_read && !o_d_write && !o_is_halted)
                else begin
                        other_errors++;
                        $display("%s: a strobe or the halt flag is high", name);
                end
                check_value({name, " output port"}, 16'd0, o_output_port);
                check_value({name, " instruction count"}, 16'd0, o_num_inst);
        endtask

        task automatic check_output();
                string name;
                name = cur_addr < ls_start ? "alu" : (cur_addr < br_start ? "load store" : "branch");
                if (cur_addr >= br_start) begin
                        assert (o_output_port != MARKER)
                        else begin
                                other_errors++;
                                $display("%s: a skipped path put its marker on the output port", name);
                        end
                end
                assert (exp_out.size() != 0)
                else begin
                        other_errors++;
                        $display("%s: more output words than the program writes", name);
                end
                if (exp_out.size() != 0)
                        check_value(name, exp_out.pop_front(), o_output_port);
        endtask

        task automatic check_store();
                assert (exp_st_addr.size() != 0)
                else begin
                        other_errors++;
                        $display("a data write happened that the program does not contain");
                end
                if (exp_st_addr.size() != 0) begin
                        check_value("store address", exp_st_addr.pop_front(), o_d_address);
                        check_value("store data", exp_st_data.pop_front(), o_d_wdata);
                end
                dmem[o_d_address[7:0]] = o_d_wdata;
        endtask

        // outputs sampled mid-cycle
        always @(negedge i_clk) begin
                i_req = o_i_read;
                i_addr = o_i_address;
                d_req = o_d_read;
                d_addr = o_d_address;
                if (o_i_read && first_fetch) begin
                        first_fetch = 1'b0;
                        check_value("first fetch address", 16'd0, o_i_address);
                end
                if (o_d_write)
                        check_store();
                if (o_num_inst != prev_num) begin
                        prev_num = o_num_inst;
                        if (cur_inst[15:12] == OP_RTYPE && cur_inst[5:0] == FN_WWD)
                                check_output();
                end
        end

        // memories answer one cycle after the strobe
        always @(posedge i_clk) begin
                #2;
                if (i_req) begin
                        cur_inst = imem[i_addr[7:0]];
                        cur_addr = i_addr;
                end
                i_i_data = i_req ? imem[i_addr[7:0]] : '0;
                i_d_rdata = d_req ? dmem[d_addr[7:0]] : '0;
        end

        initial begin
                int cycles;
                i_rst = 1'b1;
                i_i_data = '0;
                i_d_rdata = '0;
                {i_req, d_req, first_fetch} = 3'b001;
                {prev_num, cur_inst, cur_addr} = '0;
                value_errors = 0;
                other_errors = 0;
                lfsr = 16'd6340;
                for (int a = 0; a < MEM_DEPTH; a++)
                        dmem[a] = {a[7:0], ~a[7:0]} ^ 16'h0f0f;
                build_program();
                run_model();
                repeat (4) begin
                        @(negedge i_clk);
                        check_idle("reset");
                end
                @(posedge i_clk);
                #2 i_rst = 1'b0;
                @(negedge i_clk);
                check_idle("after reset");
                cycles = 0;
                while (!o_is_halted && cycles < HALT_LIMIT) begin
                        @(negedge i_clk);
                        cycles++;
                end
                if (!o_is_halted) begin
                        other_errors++;
                        $display("timeout: the processor did not halt in %0d cycles", HALT_LIMIT);
                end else begin
                        check_value("instruction count", model_count[15:0], o_num_inst);
                        assert (exp_out.size() == 0 && exp_st_addr.size() == 0)
                        else begin
                                other_errors++;
                                $display("halted before all expected outputs and stores were seen");
                        end
                        repeat (20) begin
                                @(negedge i_clk);
                                assert (o_is_halted && !o_i_read && !o_d_read && !o_d_write)
                                else begin
                                        other_errors++;
                                        $display("activity or a dropped halt flag after halt");
                                end
                        end
                end
                $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
                if (value_errors + other_errors == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

endmodule

// File: src.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/cpu.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
